//--- src/lc3b_pkg.sv
package lc3b_pkg;

	localparam int word_width  = 16;
	localparam int reg_count   = 8;
	localparam int flush_depth = 4;  // IF/ID, ID/EX, EX/MEM, MEM/WB

	typedef logic [word_width-1:0] lc3b_word;
	typedef logic [2:0] lc3b_reg;
	typedef logic [2:0] lc3b_nzp;  // n, z, p

	localparam lc3b_word nop_word = '0;  // BR with no condition bits

	// lc3b encodings, only the subset this core runs
	typedef enum logic [3:0] {
		op_br  = 4'b0000,
		op_add = 4'b0001,
		op_and = 4'b0101,
		op_ldr = 4'b0110,
		op_str = 4'b0111,
		op_not = 4'b1001,
		op_lea = 4'b1110
	} lc3b_opcode;

	typedef enum logic [1:0] {
		alu_add,
		alu_and,
		alu_not,
		alu_pass  // b straight through
	} lc3b_aluop;

	// register form of ADD / AND
	typedef struct packed {
		lc3b_opcode opcode;
		lc3b_reg    dest;
		lc3b_reg    sr1;
		logic       imm_flag;
		logic [1:0] unused;
		lc3b_reg    sr2;
	} lc3b_instr_rr;

	// immediate form, same word
	typedef struct packed {
		lc3b_opcode opcode;
		lc3b_reg    dest;
		lc3b_reg    sr1;
		logic       imm_flag;
		logic [4:0] imm5;
	} lc3b_instr_imm;

	typedef union packed {
		lc3b_instr_rr  rr;
		lc3b_instr_imm ri;
	} lc3b_instr;

endpackage

//--- src/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage
(
	input  logic               clk,
	input  logic               reset,
	input  logic               stall,
	input  logic               branch_taken,
	input  lc3b_pkg::lc3b_word branch_target,
	input  lc3b_pkg::lc3b_word I_mem_rdata,
	input  logic               I_mem_resp,
	output lc3b_pkg::lc3b_word I_mem_address,
	output logic               I_mem_read,
	output lc3b_pkg::lc3b_word pc_id,
	output lc3b_pkg::lc3b_instr ir_id,
	output logic               valid_id
);
	import lc3b_pkg::*;

	lc3b_word pc;         // address of the word being fetched
	lc3b_word pc_plus2;
	lc3b_word held_word;  // response parked while the rest of the pipe waits
	lc3b_word fetched;
	logic     word_held;
	logic     have_word;

	assign pc_plus2      = pc + 16'd2;
	assign I_mem_address = pc;  // stable while stalled, pc only moves on advance
	assign have_word     = I_mem_resp | word_held;
	assign fetched       = word_held ? held_word : I_mem_rdata;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			pc         <= '0;
			I_mem_read <= 1'b0;
			word_held  <= 1'b0;
			valid_id   <= 1'b0;
		end
		else if (stall)
		begin
			// only a data wait can stall us here with a response in hand
			if (I_mem_resp)
			begin
				word_held  <= 1'b1;
				I_mem_read <= 1'b0;  // request done, don't ask again
			end
		end
		else
		begin
			I_mem_read <= 1'b1;  // next request starts right away
			word_held  <= 1'b0;
			if (branch_taken)
			begin
				pc       <= branch_target;
				valid_id <= 1'b0;  // in-flight word belongs to the wrong path
			end
			else if (have_word)
			begin
				pc       <= pc_plus2;
				valid_id <= 1'b1;
			end
			else
				valid_id <= 1'b0;  // first cycle out of reset, nothing fetched yet
		end
	end

	always_ff @(posedge clk)
	begin
		if (I_mem_resp)
			held_word <= I_mem_rdata;
		if (!stall)
		begin
			pc_id <= pc_plus2;  // lc3b pc-relative math uses pc+2
			ir_id <= (branch_taken | ~have_word) ? nop_word : fetched;
		end
	end

endmodule

//--- src/decode_stage.sv
`timescale 1ns/1ps

module decode_stage
(
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 stall,
	input  logic                 flush,
	input  lc3b_pkg::lc3b_word   pc_id,
	input  lc3b_pkg::lc3b_instr  ir_id,
	input  logic                 valid_id,
	input  logic                 reg_write,
	input  lc3b_pkg::lc3b_reg    reg_dest,
	input  lc3b_pkg::lc3b_word   reg_data,
	output lc3b_pkg::lc3b_word   sr1_ex,
	output lc3b_pkg::lc3b_word   sr2_ex,
	output lc3b_pkg::lc3b_word   imm_ex,
	output lc3b_pkg::lc3b_word   pc_ex,
	output lc3b_pkg::lc3b_aluop  aluop_ex,
	output logic [1:0]           mux1_sel_ex,
	output logic [1:0]           mux2_sel_ex,
	output lc3b_pkg::lc3b_opcode opcode_ex,
	output lc3b_pkg::lc3b_reg    dest_ex,
	output lc3b_pkg::lc3b_nzp    nzp_ex,
	output logic                 valid_ex
);
	import lc3b_pkg::*;

	lc3b_word   regfile [reg_count];
	lc3b_reg    sr2_idx;
	lc3b_word   imm;
	lc3b_aluop  aluop;
	logic [1:0] mux1_sel;  // 0 sr1, 1 pc
	logic [1:0] mux2_sel;  // 0 sr2, 1 imm
	logic       supported;

	// written by writeback, old value seen on a same-cycle read
	always_ff @(posedge clk)
	begin
		if (reg_write)
			regfile[reg_dest] <= reg_data;
	end

	always_comb
	begin
		aluop     = alu_pass;
		mux1_sel  = 2'd0;
		mux2_sel  = 2'd0;
		imm       = '0;
		sr2_idx   = ir_id.rr.sr2;
		supported = 1'b1;
		case (ir_id.rr.opcode)
			op_add, op_and:
			begin
				aluop = (ir_id.rr.opcode == op_add) ? alu_add : alu_and;
				if (ir_id.rr.imm_flag)  // immediate view of the word
				begin
					mux2_sel = 2'd1;
					imm      = {{11{ir_id.ri.imm5[4]}}, ir_id.ri.imm5};
				end
			end
			op_not:
				aluop = alu_not;
			op_ldr, op_str:
			begin
				aluop    = alu_add;  // base + offset6*2
				mux2_sel = 2'd1;
				imm      = {{9{ir_id[5]}}, ir_id[5:0], 1'b0};
				sr2_idx  = ir_id.rr.dest;  // STR source sits in the dest field
			end
			op_br, op_lea:
			begin
				aluop    = alu_add;  // pc + offset9*2
				mux1_sel = 2'd1;
				mux2_sel = 2'd1;
				imm      = {{6{ir_id[8]}}, ir_id[8:0], 1'b0};
			end
			default:
				supported = 1'b0;  // everything else is a bubble
		endcase
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			valid_ex <= 1'b0;
		else if (!stall)
			valid_ex <= valid_id & supported & ~flush;
	end

	always_ff @(posedge clk)
	begin
		if (!stall)
		begin
			sr1_ex      <= regfile[ir_id.rr.sr1];
			sr2_ex      <= regfile[sr2_idx];
			imm_ex      <= imm;
			pc_ex       <= pc_id;
			aluop_ex    <= aluop;
			mux1_sel_ex <= mux1_sel;
			mux2_sel_ex <= mux2_sel;
			opcode_ex   <= ir_id.rr.opcode;
			dest_ex     <= ir_id.rr.dest;
			nzp_ex      <= ir_id[11:9];  // BR condition bits
		end
	end

endmodule

//--- src/execute_stage.sv
`timescale 1ns/1ps

module execute_stage
(
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 stall,
	input  logic                 flush,
	input  lc3b_pkg::lc3b_word   sr1_ex,
	input  lc3b_pkg::lc3b_word   sr2_ex,
	input  lc3b_pkg::lc3b_word   imm_ex,
	input  lc3b_pkg::lc3b_word   pc_ex,
	input  lc3b_pkg::lc3b_aluop  aluop_ex,
	input  logic [1:0]           mux1_sel_ex,
	input  logic [1:0]           mux2_sel_ex,
	input  lc3b_pkg::lc3b_opcode opcode_ex,
	input  lc3b_pkg::lc3b_reg    dest_ex,
	input  lc3b_pkg::lc3b_nzp    nzp_ex,
	input  logic                 valid_ex,
	output lc3b_pkg::lc3b_word   alu_out_mem,
	output lc3b_pkg::lc3b_word   sr2_mem,
	output lc3b_pkg::lc3b_opcode opcode_mem,
	output lc3b_pkg::lc3b_reg    dest_mem,
	output lc3b_pkg::lc3b_nzp    nzp_mem,
	output logic                 valid_mem
);
	import lc3b_pkg::*;

	lc3b_word alu_a;
	lc3b_word alu_b;
	lc3b_word alu_out;

	assign alu_a = (mux1_sel_ex == 2'd1) ? pc_ex : sr1_ex;   // pc for BR / LEA
	assign alu_b = (mux2_sel_ex == 2'd1) ? imm_ex : sr2_ex;  // offset or imm5

	always_comb
	begin
		case (aluop_ex)
			alu_add:  alu_out = alu_a + alu_b;
			alu_and:  alu_out = alu_a & alu_b;
			alu_not:  alu_out = ~alu_a;
			alu_pass: alu_out = alu_b;
		endcase
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			valid_mem <= 1'b0;
		else if (!stall)
			valid_mem <= valid_ex & ~flush;
	end

	always_ff @(posedge clk)
	begin
		if (!stall)
		begin
			alu_out_mem <= alu_out;
			sr2_mem     <= sr2_ex;  // store data for STR
			opcode_mem  <= opcode_ex;
			dest_mem    <= dest_ex;
			nzp_mem     <= nzp_ex;
		end
	end

endmodule

//--- src/mem_stage.sv
`timescale 1ns/1ps

module mem_stage
(
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 stall,
	input  logic                 flush,
	input  lc3b_pkg::lc3b_word   alu_out_mem,
	input  lc3b_pkg::lc3b_word   sr2_mem,
	input  lc3b_pkg::lc3b_opcode opcode_mem,
	input  lc3b_pkg::lc3b_reg    dest_mem,
	input  lc3b_pkg::lc3b_nzp    nzp_mem,
	input  logic                 valid_mem,
	input  lc3b_pkg::lc3b_word   D_mem_rdata,
	input  logic                 D_mem_resp,
	output lc3b_pkg::lc3b_word   D_mem_address,
	output lc3b_pkg::lc3b_word   D_mem_wdata,
	output logic                 D_mem_read,
	output logic                 D_mem_write,
	output logic                 data_stall,
	output lc3b_pkg::lc3b_word   result_wb,
	output lc3b_pkg::lc3b_opcode opcode_wb,
	output lc3b_pkg::lc3b_reg    dest_wb,
	output lc3b_pkg::lc3b_nzp    nzp_wb,
	output logic                 valid_wb
);
	import lc3b_pkg::*;

	logic     is_load;
	logic     is_store;
	logic     done;       // access answered, waiting on fetch
	lc3b_word load_buf;
	lc3b_word load_data;

	// a slot behind a taken branch never touches memory
	assign is_load  = valid_mem & ~flush & (opcode_mem == op_ldr);
	assign is_store = valid_mem & ~flush & (opcode_mem == op_str);

	assign D_mem_read    = is_load & ~done;
	assign D_mem_write   = is_store & ~done;
	assign D_mem_address = alu_out_mem;
	assign D_mem_wdata   = sr2_mem;
	assign data_stall    = (D_mem_read | D_mem_write) & ~D_mem_resp;
	assign load_data     = done ? load_buf : D_mem_rdata;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			done     <= 1'b0;
			valid_wb <= 1'b0;
		end
		else if (stall)
		begin
			if (D_mem_resp)
				done <= 1'b1;  // drop the level, keep the data
		end
		else
		begin
			done     <= 1'b0;
			valid_wb <= valid_mem & ~flush;
		end
	end

	always_ff @(posedge clk)
	begin
		if (D_mem_resp)
			load_buf <= D_mem_rdata;
		if (!stall)
		begin
			result_wb <= (opcode_mem == op_ldr) ? load_data : alu_out_mem;
			opcode_wb <= opcode_mem;
			dest_wb   <= dest_mem;
			nzp_wb    <= nzp_mem;
		end
	end

endmodule

//--- src/writeback_stage.sv
`timescale 1ns/1ps

module writeback_stage
(
	input  logic                 clk,
	input  logic                 reset,
	input  lc3b_pkg::lc3b_word   result_wb,
	input  lc3b_pkg::lc3b_opcode opcode_wb,
	input  lc3b_pkg::lc3b_reg    dest_wb,
	input  lc3b_pkg::lc3b_nzp    nzp_wb,
	input  logic                 valid_wb,
	output logic                 reg_write,
	output lc3b_pkg::lc3b_reg    reg_dest,
	output lc3b_pkg::lc3b_word   reg_data,
	output logic                 branch_taken,
	output lc3b_pkg::lc3b_word   branch_target
);
	import lc3b_pkg::*;

	lc3b_nzp cc;
	lc3b_nzp gencc;
	logic    writes_reg;

	always_comb
	begin
		case (opcode_wb)
			op_add, op_and, op_not, op_ldr, op_lea: writes_reg = 1'b1;
			default:                                writes_reg = 1'b0;
		endcase
	end

	assign reg_write = valid_wb & writes_reg;
	assign reg_dest  = dest_wb;
	assign reg_data  = result_wb;

	// sign and zero of the value going into the register file
	assign gencc = result_wb[word_width-1] ? 3'b100 :
	               (result_wb == '0)       ? 3'b010 : 3'b001;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			cc <= '0;  // no BR taken until something sets cc
		else if (reg_write)
			cc <= gencc;  // LEA updates cc too
	end

	// BR target already computed by the ALU as pc + offset9*2
	assign branch_taken  = valid_wb & (opcode_wb == op_br) & (|(nzp_wb & cc));
	assign branch_target = result_wb;

endmodule

//--- src/datapath.sv
`timescale 1ns/1ps

module datapath
(
	input  logic               clk,
	input  logic               reset,

	// data memory
	output lc3b_pkg::lc3b_word D_mem_address,
	input  logic               D_mem_resp,
	output logic               D_mem_read,
	input  lc3b_pkg::lc3b_word D_mem_rdata,
	output logic               D_mem_write,
	output lc3b_pkg::lc3b_word D_mem_wdata,

	// instruction memory
	output lc3b_pkg::lc3b_word I_mem_address,
	input  logic               I_mem_resp,
	output logic               I_mem_read,
	input  lc3b_pkg::lc3b_word I_mem_rdata
);
	import lc3b_pkg::*;

	logic       stall;
	logic       data_stall;
	logic       branch_taken;
	lc3b_word   branch_target;
	logic [flush_depth-1:0] flush_slot;  // one per younger pipeline register

	// IF/ID
	lc3b_word   pc_id;
	lc3b_instr  ir_id;
	logic       valid_id;

	// ID/EX
	lc3b_word   sr1_ex;
	lc3b_word   sr2_ex;
	lc3b_word   imm_ex;
	lc3b_word   pc_ex;
	lc3b_aluop  aluop_ex;
	logic [1:0] mux1_sel_ex;
	logic [1:0] mux2_sel_ex;
	lc3b_opcode opcode_ex;
	lc3b_reg    dest_ex;
	lc3b_nzp    nzp_ex;
	logic       valid_ex;

	// EX/MEM
	lc3b_word   alu_out_mem;
	lc3b_word   sr2_mem;
	lc3b_opcode opcode_mem;
	lc3b_reg    dest_mem;
	lc3b_nzp    nzp_mem;
	logic       valid_mem;

	// MEM/WB
	lc3b_word   result_wb;
	lc3b_opcode opcode_wb;
	lc3b_reg    dest_wb;
	lc3b_nzp    nzp_wb;
	logic       valid_wb;

	// register file write port
	logic       reg_write;
	lc3b_reg    reg_dest;
	lc3b_word   reg_data;

	// whole pipe holds on either memory wait, a strobe releases it at once
	assign stall      = (I_mem_read & ~I_mem_resp) | data_stall;
	assign flush_slot = {flush_depth{branch_taken}};

	fetch_stage fetch
	(
		.clk,
		.reset,
		.stall,
		.branch_taken  (flush_slot[0]),
		.branch_target,
		.I_mem_rdata,
		.I_mem_resp,
		.I_mem_address,
		.I_mem_read,
		.pc_id,
		.ir_id,
		.valid_id
	);

	decode_stage decode
	(
		.clk,
		.reset,
		.stall,
		.flush (flush_slot[1]),
		.pc_id,
		.ir_id,
		.valid_id,
		.reg_write,
		.reg_dest,
		.reg_data,
		.sr1_ex,
		.sr2_ex,
		.imm_ex,
		.pc_ex,
		.aluop_ex,
		.mux1_sel_ex,
		.mux2_sel_ex,
		.opcode_ex,
		.dest_ex,
		.nzp_ex,
		.valid_ex
	);

	execute_stage execute
	(
		.clk,
		.reset,
		.stall,
		.flush (flush_slot[2]),
		.sr1_ex,
		.sr2_ex,
		.imm_ex,
		.pc_ex,
		.aluop_ex,
		.mux1_sel_ex,
		.mux2_sel_ex,
		.opcode_ex,
		.dest_ex,
		.nzp_ex,
		.valid_ex,
		.alu_out_mem,
		.sr2_mem,
		.opcode_mem,
		.dest_mem,
		.nzp_mem,
		.valid_mem
	);

	mem_stage mem
	(
		.clk,
		.reset,
		.stall,
		.flush (flush_slot[3]),
		.alu_out_mem,
		.sr2_mem,
		.opcode_mem,
		.dest_mem,
		.nzp_mem,
		.valid_mem,
		.D_mem_rdata,
		.D_mem_resp,
		.D_mem_address,
		.D_mem_wdata,
		.D_mem_read,
		.D_mem_write,
		.data_stall,
		.result_wb,
		.opcode_wb,
		.dest_wb,
		.nzp_wb,
		.valid_wb
	);

	writeback_stage writeback
	(
		.clk,
		.reset,
		.result_wb,
		.opcode_wb,
		.dest_wb,
		.nzp_wb,
		.valid_wb,
		.reg_write,
		.reg_dest,
		.reg_data,
		.branch_taken,
		.branch_target
	);

endmodule

//--- tests/mem_model.sv
`timescale 1ns/1ps

module mem_model
(
	input  logic        clk,
	input  logic        reset,
	input  logic [15:0] I_mem_address,
	input  logic        I_mem_read,
	output logic [15:0] I_mem_rdata,
	output logic        I_mem_resp,
	input  logic [15:0] D_mem_address,
	input  logic        D_mem_read,
	input  logic        D_mem_write,
	input  logic [15:0] D_mem_wdata,
	output logic [15:0] D_mem_rdata,
	output logic        D_mem_resp
);
	logic [15:0] imem [256];  // word addressed, byte address bits 8:1
	logic [15:0] dmem [256];
	integer      seed = 51842;
	int          i_wait = -1;  // -1 idle, else cycles left before resp
	int          d_wait = -1;

	// 0 to 3 extra cycles per access
	function int draw_latency();
		return int'($unsigned($random(seed)) % 4);
	endfunction

	initial
	begin
		I_mem_rdata = '0;
		I_mem_resp  = 1'b0;
		D_mem_rdata = '0;
		D_mem_resp  = 1'b0;
	end

	always @(posedge clk)
	begin : imem_port
		logic [15:0] addr;
		addr = I_mem_address;  // sampled before the edge updates land
		if (reset)
		begin
			i_wait = -1;
			#1 I_mem_resp = 1'b0;
		end
		else if (I_mem_resp)
			#1 I_mem_resp = 1'b0;  // strobe is one cycle only
		else if (I_mem_read)
		begin
			if (i_wait < 0)
				i_wait = draw_latency();  // new request
			if (i_wait == 0)
			begin
				i_wait = -1;
				#1;
				I_mem_rdata = imem[addr[8:1]];
				I_mem_resp  = 1'b1;
			end
			else
				i_wait--;
		end
	end

	always @(posedge clk)
	begin : dmem_port
		logic [15:0] addr;
		logic [15:0] wdata;
		logic        wr;
		addr  = D_mem_address;
		wdata = D_mem_wdata;
		wr    = D_mem_write;
		if (reset)
		begin
			d_wait = -1;
			#1 D_mem_resp = 1'b0;
		end
		else if (D_mem_resp)
			#1 D_mem_resp = 1'b0;
		else if (D_mem_read || D_mem_write)
		begin
			if (d_wait < 0)
				d_wait = draw_latency();
			if (d_wait == 0)
			begin
				d_wait = -1;
				#1;
				if (wr)
					dmem[addr[8:1]] = wdata;
				else
					D_mem_rdata = dmem[addr[8:1]];
				D_mem_resp = 1'b1;
			end
			else
				d_wait--;
		end
	end

endmodule

//--- tests/tb_datapath.sv
`timescale 1ns/1ps

module tb_datapath;
	import lc3b_pkg::*;

	logic        clk;
	logic        reset;
	logic [15:0] I_mem_address;
	logic        I_mem_read;
	logic [15:0] I_mem_rdata;
	logic        I_mem_resp;
	logic [15:0] D_mem_address;
	logic        D_mem_read;
	logic        D_mem_write;
	logic [15:0] D_mem_wdata;
	logic [15:0] D_mem_rdata;
	logic        D_mem_resp;

	int          errors = 0;
	int          pc_idx = 0;    // next imem word to fill
	int          n_exp = 0;
	int          store_idx;     // stores seen so far
	int          cycles;
	logic [15:0] exp_addr [32];
	logic [15:0] exp_data [32];
	logic [15:0] exp_addr_now;
	logic [15:0] exp_data_now;
	logic [15:0] skip_addr = 16'd44;  // store behind the taken BR
	int          lea_idx;

	datapath DUT
	(
		.clk,
		.reset,
		.D_mem_address,
		.D_mem_resp,
		.D_mem_read,
		.D_mem_rdata,
		.D_mem_write,
		.D_mem_wdata,
		.I_mem_address,
		.I_mem_resp,
		.I_mem_read,
		.I_mem_rdata
	);

	mem_model mem
	(
		.clk,
		.reset,
		.I_mem_address,
		.I_mem_read,
		.I_mem_rdata,
		.I_mem_resp,
		.D_mem_address,
		.D_mem_read,
		.D_mem_write,
		.D_mem_wdata,
		.D_mem_rdata,
		.D_mem_resp
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;  // 8 ns period
	end

	// instruction encoders
	function logic [15:0] rr(input logic [3:0] op, input logic [2:0] dr, sr1, sr2);
		return {op, dr, sr1, 3'b000, sr2};
	endfunction

	function logic [15:0] ri(input logic [3:0] op, input logic [2:0] dr, sr1,
		input logic [4:0] imm5);
		return {op, dr, sr1, 1'b1, imm5};
	endfunction

	function logic [15:0] mem_op(input logic [3:0] op, input logic [2:0] r, base,
		input logic [5:0] off6);
		return {op, r, base, off6};
	endfunction

	function logic [15:0] pc_rel(input logic [3:0] op, input logic [2:0] f,
		input logic [8:0] off9);
		return {op, f, off9};
	endfunction

	task emit(input logic [15:0] w);
		mem.imem[pc_idx] = w;
		pc_idx++;
	endtask

	task spacing();  // three independent slots between writer and reader
		emit(nop_word);
		emit(nop_word);
		emit(nop_word);
	endtask

	task expect_store(input logic [15:0] a, input logic [15:0] d);
		exp_addr[n_exp] = a;
		exp_data[n_exp] = d;
		n_exp++;
	endtask

	assign exp_addr_now = (store_idx < 32) ? exp_addr[store_idx] : 16'h0;
	assign exp_data_now = (store_idx < 32) ? exp_data[store_idx] : 16'h0;

	always @(posedge clk or posedge reset)
	begin
		if (reset)
			store_idx <= 0;
		else if (D_mem_write && D_mem_resp)
			store_idx <= store_idx + 1;  // write lands on this edge
	end

	a_reset_idle: assert property (@(posedge clk)
		!reset || (!I_mem_read && !D_mem_read && !D_mem_write))
	else
	begin
		errors++;
		$display("%0t: memory request active during reset", $time);
	end

	a_no_rw: assert property (@(posedge clk) disable iff (reset)
		!(D_mem_read && D_mem_write))
	else
	begin
		errors++;
		$display("%0t: data read and write high in the same cycle", $time);
	end

	a_extra_store: assert property (@(posedge clk) disable iff (reset)
		!(D_mem_write && D_mem_resp) || (store_idx < n_exp))
	else
	begin
		errors++;
		$display("%0t: store at %h beyond the expected list", $time, D_mem_address);
	end

	a_store_addr: assert property (@(posedge clk) disable iff (reset)
		!(D_mem_write && D_mem_resp) || (D_mem_address == exp_addr_now))
	else
	begin
		errors++;
		$display("ERR %0t D_mem_address exp %h got %h", $time, exp_addr_now, D_mem_address);
	end

	a_store_data: assert property (@(posedge clk) disable iff (reset)
		!(D_mem_write && D_mem_resp) || (D_mem_wdata == exp_data_now))
	else
	begin
		errors++;
		$display("ERR %0t D_mem_wdata exp %h got %h", $time, exp_data_now, D_mem_wdata);
	end

	a_skipped: assert property (@(posedge clk) disable iff (reset)
		!(D_mem_write && D_mem_address == skip_addr))
	else
	begin
		errors++;
		$display("%0t: store skipped by taken branch was written", $time);
	end

	initial
	begin
		reset = 1'b1;
		for (int i = 0; i < 256; i++)
		begin
			mem.imem[i] = nop_word;
			mem.dmem[i] = {i[7:0], ~i[7:0]};  // each word tagged by its index
		end

		// clear r0..r6 since x & 0 is 0
		for (int r = 0; r < 7; r++)
			emit(ri(op_and, 3'(r), 3'(r), 5'd0));
		spacing();
		emit(ri(op_add, 3'd1, 3'd0, 5'd7));     // r1 = 7
		emit(ri(op_add, 3'd2, 3'd0, 5'h1D));    // r2 = -3
		emit(ri(op_add, 3'd3, 3'd0, 5'd14));    // r3 = 14
		spacing();
		emit(rr(op_add, 3'd4, 3'd1, 3'd2));     // 7 + -3
		emit(ri(op_and, 3'd5, 3'd3, 5'd5));     // 14 & 5
		emit(rr(op_and, 3'd6, 3'd1, 3'd3));     // 7 & 14
		emit({4'(op_not), 3'd7, 3'd2, 6'h3F});  // ~(-3)
		spacing();
		emit(mem_op(op_str, 3'd4, 3'd0, 6'd1));
		expect_store(16'd2, 16'd4);
		emit(mem_op(op_str, 3'd5, 3'd0, 6'd2));
		expect_store(16'd4, 16'd4);
		emit(mem_op(op_str, 3'd6, 3'd0, 6'd3));
		expect_store(16'd6, 16'd6);
		emit(mem_op(op_str, 3'd7, 3'd0, 6'd4));
		expect_store(16'd8, 16'h0002);
		emit(mem_op(op_str, 3'd1, 3'd0, 6'd5));
		expect_store(16'd10, 16'd7);
		emit(mem_op(op_str, 3'd2, 3'd0, 6'd6));
		expect_store(16'd12, 16'hFFFD);
		emit(mem_op(op_str, 3'd3, 3'd3, 6'd7));  // base 14 + 2*7
		expect_store(16'd28, 16'd14);

		// load a preloaded word and store it elsewhere
		emit(mem_op(op_ldr, 3'd4, 3'd0, 6'd25));  // addr 50 is word 25
		spacing();
		emit(mem_op(op_str, 3'd4, 3'd0, 6'd20));
		expect_store(16'd40, {8'd25, ~8'd25});

		lea_idx = pc_idx;
		emit(pc_rel(op_lea, 3'd5, 9'd10));
		spacing();
		emit(mem_op(op_str, 3'd5, 3'd0, 6'd21));
		expect_store(16'd42, 16'(lea_idx * 2 + 2 + 20));  // pc+2 plus 2*offset9

		// cc = n so BRn skips one store
		emit(ri(op_add, 3'd6, 3'd0, 5'h1F));
		spacing();
		emit(pc_rel(op_br, 3'b100, 9'd1));
		emit(mem_op(op_str, 3'd6, 3'd0, 6'd22));  // addr 44 must never appear
		emit(mem_op(op_str, 3'd1, 3'd0, 6'd23));
		expect_store(16'd46, 16'd7);
		emit(pc_rel(op_br, 3'b010, 9'd1));        // BRz not taken
		emit(mem_op(op_str, 3'd7, 3'd0, 6'd24));
		expect_store(16'd48, 16'h0002);
		emit(pc_rel(op_br, 3'b111, 9'h1FF));      // park on itself

		for (int i = 0; i < 8; i++)
			@(posedge clk);
		#1 reset = 1'b0;

		a_idle_after: assert (!I_mem_read && !D_mem_read && !D_mem_write)
		else
		begin
			errors++;
			$display("%0t: memory request active right after reset", $time);
		end

		cycles = 0;
		while (!I_mem_read && cycles < 10)
		begin
			@(posedge clk);
			cycles++;
		end
		#1;
		if (!I_mem_read)
		begin
			errors++;
			$display("timeout waiting for the first instruction fetch");
		end
		a_first_fetch: assert (I_mem_address == 16'h0000)
		else
		begin
			errors++;
			$display("ERR %0t I_mem_address exp 0000 got %h", $time, I_mem_address);
		end

		cycles = 0;
		while (store_idx < n_exp && cycles < 5000)
		begin
			@(posedge clk);
			cycles++;
		end
		if (store_idx < n_exp)
		begin
			errors++;
			$display("timeout with only %0d of %0d stores seen", store_idx, n_exp);
		end

		// idle on the branch loop where a stray store would show
		cycles = 0;
		while (cycles < 100)
		begin
			@(posedge clk);
			cycles++;
		end

		$display("errors %0d, stores %0d of %0d", errors, store_idx, n_exp);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

//--- sim.f
src/lc3b_pkg.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/mem_stage.sv
src/writeback_stage.sv
src/datapath.sv
tests/mem_model.sv
tests/tb_datapath.sv

//--- run.sh
#!/bin/sh
# build and run the datapath testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_datapath \
	--Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "^Verification passed$"; then
	exit 0
fi
exit 1
